// ==== txBufPkg.sv ====
package txBufPkg;

    // Line geometry
    localparam int laneCount = 4;
    localparam int wordWidth = 32;
    localparam int lineWidth = laneCount * wordWidth;

    // Buffer sizing
    localparam int maxPayloadBytes = 64;
    localparam int maxPacketLines = (maxPayloadBytes * 8) / lineWidth;
    localparam int depthPackets = 4;
    localparam int laneFifoDepth = maxPacketLines * depthPackets;

    // Lane entry layout is word, start flag, end flag
    localparam int entryEndBit = 0;
    localparam int entryStartBit = 1;
    localparam int entryWordLsb = 2;
    localparam int entryWidth = wordWidth + 2;

    localparam int fifoPtrWidth = $clog2(laneFifoDepth);
    localparam int fifoCountWidth = $clog2(laneFifoDepth + 1);
    localparam int pktCountWidth = $clog2(depthPackets + 1);

    typedef logic [wordWidth-1:0] word_t;
    typedef logic [lineWidth-1:0] line_t;
    typedef logic [laneCount-1:0] laneMask_t;
    typedef logic [entryWidth-1:0] laneEntry_t;
    typedef logic [pktCountWidth-1:0] pktCount_t;
    typedef logic [$clog2(laneCount)-1:0] laneIdx_t;
    typedef logic [fifoPtrWidth-1:0] fifoPtr_t;
    typedef logic [fifoCountWidth-1:0] fifoCount_t;

endpackage

// ==== txPipeline.sv ====
`timescale 1ns/1ps

module txPipeline (
    input  logic                 CLK,
    input  logic                 RST_IN,
    input  txBufPkg::laneEntry_t WR_DATA,
    input  logic                 WR_VALID,
    output logic                 WR_READY,
    output txBufPkg::laneEntry_t RD_DATA,
    output logic                 RD_VALID,
    input  logic                 RD_READY
);

    txBufPkg::laneEntry_t entryQ;
    logic                 validQ;
    logic                 wrFire;

    // Empty slot, or the held entry leaves this cycle
    assign WR_READY = !validQ || RD_READY;
    assign wrFire = WR_VALID && WR_READY;

    assign RD_DATA = entryQ;
    assign RD_VALID = validQ;

    always_ff @(posedge CLK) begin
        if (RST_IN) begin
            validQ <= 1'b0;
        end else if (WR_READY) begin
            validQ <= WR_VALID;
        end
    end

    always_ff @(posedge CLK) begin
        if (wrFire) begin
            entryQ <= WR_DATA;
        end
    end

endmodule

// ==== txLaneFifo.sv ====
`timescale 1ns/1ps

module txLaneFifo (
    input  logic                 CLK,
    input  logic                 RST_IN,
    input  txBufPkg::laneEntry_t WR_DATA,
    input  logic                 WR_VALID,
    output logic                 WR_READY,
    output txBufPkg::laneEntry_t RD_DATA,
    output logic                 RD_VALID,
    input  logic                 RD_READY
);

    txBufPkg::laneEntry_t mem [txBufPkg::laneFifoDepth];
    txBufPkg::fifoPtr_t   wrPtr;
    txBufPkg::fifoPtr_t   rdPtr;
    txBufPkg::fifoCount_t fillCount;
    logic                 push;
    logic                 pop;

    assign WR_READY = fillCount != txBufPkg::fifoCount_t'(txBufPkg::laneFifoDepth);
    assign RD_VALID = fillCount != '0;
    assign push = WR_VALID && WR_READY;
    assign pop = RD_VALID && RD_READY;

    // Head entry is visible without a read cycle
    assign RD_DATA = mem[rdPtr];

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wrPtr] <= WR_DATA;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST_IN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fillCount <= '0;
        end else begin
            if (push) begin
                if (wrPtr == txBufPkg::fifoPtr_t'(txBufPkg::laneFifoDepth - 1)) begin
                    wrPtr <= '0;
                end else begin
                    wrPtr <= wrPtr + 1'b1;
                end
            end
            if (pop) begin
                if (rdPtr == txBufPkg::fifoPtr_t'(txBufPkg::laneFifoDepth - 1)) begin
                    rdPtr <= '0;
                end else begin
                    rdPtr <= rdPtr + 1'b1;
                end
            end
            if (push && !pop) begin
                fillCount <= fillCount + 1'b1;
            end else if (pop && !push) begin
                fillCount <= fillCount - 1'b1;
            end
        end
    end

endmodule

// ==== txDataFifo.sv ====
`timescale 1ns/1ps

module txDataFifo (
    input  logic                CLK,
    input  logic                RST_IN,
    input  txBufPkg::line_t     LINE_DATA,
    input  logic                LINE_VALID,
    input  logic                LINE_START,
    input  txBufPkg::laneMask_t LINE_WORD_VALID,
    input  txBufPkg::laneMask_t LINE_END_FLAGS,
    output logic                LINE_READY,
    input  txBufPkg::laneMask_t RD_WORD_READY,
    output txBufPkg::line_t     RD_DATA,
    output logic                RD_START,
    output txBufPkg::laneMask_t RD_END_FLAGS,
    output txBufPkg::laneMask_t RD_WORD_VALID,
    output logic                RD_PACKET_VALID
);

    txBufPkg::laneEntry_t inEntry [txBufPkg::laneCount];
    txBufPkg::laneEntry_t fifoWrEntry [txBufPkg::laneCount];
    txBufPkg::laneEntry_t fifoRdEntry [txBufPkg::laneCount];
    txBufPkg::laneEntry_t outEntry [txBufPkg::laneCount];
    txBufPkg::laneMask_t  inSliceReady;
    txBufPkg::laneMask_t  fifoWrValid;
    txBufPkg::laneMask_t  fifoWrReady;
    txBufPkg::laneMask_t  fifoWrEnd;
    txBufPkg::laneMask_t  fifoRdValid;
    txBufPkg::laneMask_t  fifoRdReady;
    txBufPkg::laneMask_t  fifoRdEnd;
    txBufPkg::pktCount_t  pktCount;
    logic                 pendingEnd;
    logic                 pktIncrement;
    logic                 pktDecrement;

    // End flag still in an input slice counts against the limit
    assign pendingEnd = (fifoWrValid & fifoWrEnd) != '0;
    assign pktIncrement = (fifoWrValid & fifoWrReady & fifoWrEnd) != '0;
    assign pktDecrement = (fifoRdValid & fifoRdReady & fifoRdEnd) != '0;

    assign LINE_READY = (&inSliceReady)
        && (pktCount != txBufPkg::pktCount_t'(txBufPkg::depthPackets))
        && !(pendingEnd && pktCount == txBufPkg::pktCount_t'(txBufPkg::depthPackets - 1));

    assign RD_PACKET_VALID = pktCount != '0;
    assign RD_START = outEntry[0][txBufPkg::entryStartBit];

    always_ff @(posedge CLK) begin
        if (RST_IN) begin
            pktCount <= '0;
        end else begin
            case ({pktIncrement, pktDecrement})
                2'b10: pktCount <= pktCount + 1'b1;
                2'b01: pktCount <= pktCount - 1'b1;
                default: pktCount <= pktCount;
            endcase
        end
    end

    for (genvar i = 0; i < txBufPkg::laneCount; i++) begin : genLane
        // Only lane 0 carries the packet start
        assign inEntry[i] = {LINE_DATA[i*txBufPkg::wordWidth +: txBufPkg::wordWidth],
                             (i == 0) ? LINE_START : 1'b0,
                             LINE_END_FLAGS[i]};

        assign fifoWrEnd[i] = fifoWrEntry[i][txBufPkg::entryEndBit];
        assign fifoRdEnd[i] = fifoRdEntry[i][txBufPkg::entryEndBit];

        assign RD_DATA[i*txBufPkg::wordWidth +: txBufPkg::wordWidth] =
            outEntry[i][txBufPkg::entryWordLsb +: txBufPkg::wordWidth];
        assign RD_END_FLAGS[i] = outEntry[i][txBufPkg::entryEndBit];

        txPipeline inSlice (
            .CLK      (CLK),
            .RST_IN   (RST_IN),
            .WR_DATA  (inEntry[i]),
            .WR_VALID (LINE_VALID && LINE_READY && LINE_WORD_VALID[i]),
            .WR_READY (inSliceReady[i]),
            .RD_DATA  (fifoWrEntry[i]),
            .RD_VALID (fifoWrValid[i]),
            .RD_READY (fifoWrReady[i])
        );

        txLaneFifo laneFifo (
            .CLK      (CLK),
            .RST_IN   (RST_IN),
            .WR_DATA  (fifoWrEntry[i]),
            .WR_VALID (fifoWrValid[i]),
            .WR_READY (fifoWrReady[i]),
            .RD_DATA  (fifoRdEntry[i]),
            .RD_VALID (fifoRdValid[i]),
            .RD_READY (fifoRdReady[i])
        );

        txPipeline outSlice (
            .CLK      (CLK),
            .RST_IN   (RST_IN),
            .WR_DATA  (fifoRdEntry[i]),
            .WR_VALID (fifoRdValid[i]),
            .WR_READY (fifoRdReady[i]),
            .RD_DATA  (outEntry[i]),
            .RD_VALID (RD_WORD_VALID[i]),
            .RD_READY (RD_WORD_READY[i])
        );
    end

endmodule

// ==== txWordPacker.sv ====
`timescale 1ns/1ps

module txWordPacker (
    input  logic                CLK,
    input  logic                RST_IN,
    input  txBufPkg::word_t     IN_DATA,
    input  logic                IN_VALID,
    input  logic                IN_LAST,
    output logic                IN_READY,
    output txBufPkg::line_t     LINE_DATA,
    output logic                LINE_VALID,
    output logic                LINE_START,
    output txBufPkg::laneMask_t LINE_WORD_VALID,
    output txBufPkg::laneMask_t LINE_END_FLAGS,
    input  logic                LINE_READY
);

    txBufPkg::line_t     lineData;
    txBufPkg::laneMask_t wordValid;
    txBufPkg::laneMask_t endFlags;
    txBufPkg::laneIdx_t  laneIdx;
    logic                lineValid;
    logic                lineStart;
    logic                startNext;
    logic                inFire;
    logic                lineFire;
    logic                lineDone;

    assign IN_READY = !lineValid || LINE_READY;
    assign inFire = IN_VALID && IN_READY;
    assign lineFire = lineValid && LINE_READY;
    assign lineDone = IN_LAST || (laneIdx == txBufPkg::laneIdx_t'(txBufPkg::laneCount - 1));

    assign LINE_DATA = lineData;
    assign LINE_VALID = lineValid;
    assign LINE_START = lineStart;
    assign LINE_WORD_VALID = wordValid;
    assign LINE_END_FLAGS = endFlags;

    always_ff @(posedge CLK) begin
        if (inFire) begin
            lineData[laneIdx*txBufPkg::wordWidth +: txBufPkg::wordWidth] <= IN_DATA;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST_IN) begin
            lineValid <= 1'b0;
            lineStart <= 1'b0;
            startNext <= 1'b1;
            laneIdx <= '0;
            wordValid <= '0;
            endFlags <= '0;
        end else begin
            if (inFire) begin
                // First lane opens a fresh line
                if (laneIdx == '0) begin
                    wordValid <= txBufPkg::laneMask_t'(1);
                    endFlags <= IN_LAST ? txBufPkg::laneMask_t'(1) : '0;
                    lineStart <= startNext;
                end else begin
                    wordValid[laneIdx] <= 1'b1;
                    endFlags[laneIdx] <= IN_LAST;
                end
                startNext <= IN_LAST;
                laneIdx <= lineDone ? '0 : laneIdx + 1'b1;
            end
            if (inFire && lineDone) begin
                lineValid <= 1'b1;
            end else if (lineFire) begin
                lineValid <= 1'b0;
            end
        end
    end

endmodule

// ==== txWordSerializer.sv ====
`timescale 1ns/1ps

module txWordSerializer (
    input  logic                CLK,
    input  logic                RST_IN,
    input  txBufPkg::line_t     RD_DATA,
    input  logic                RD_START,
    input  txBufPkg::laneMask_t RD_END_FLAGS,
    input  txBufPkg::laneMask_t RD_WORD_VALID,
    input  logic                RD_PACKET_VALID,
    output txBufPkg::laneMask_t RD_WORD_READY,
    output txBufPkg::word_t     OUT_DATA,
    output logic                OUT_VALID,
    output logic                OUT_START,
    output logic                OUT_LAST,
    input  logic                OUT_READY
);

    typedef enum logic {
        idle,
        send
    } state_t;

    state_t             state;
    txBufPkg::laneIdx_t lane;
    logic               packetReady;
    logic               outFire;

    // An end flag already past the lane FIFOs also marks a whole stored packet
    assign packetReady = RD_PACKET_VALID || ((RD_WORD_VALID & RD_END_FLAGS) != '0);

    assign OUT_VALID = (state == send) && RD_WORD_VALID[lane];
    assign OUT_DATA = RD_DATA[lane*txBufPkg::wordWidth +: txBufPkg::wordWidth];
    assign OUT_START = (lane == '0) && RD_START;
    assign OUT_LAST = RD_END_FLAGS[lane];
    assign outFire = OUT_VALID && OUT_READY;

    always_comb begin
        RD_WORD_READY = '0;
        RD_WORD_READY[lane] = outFire;
    end

    always_ff @(posedge CLK) begin
        if (RST_IN) begin
            state <= idle;
            lane <= '0;
        end else begin
            case (state)
                idle: begin
                    lane <= '0;
                    if (packetReady) begin
                        state <= send;
                    end
                end
                send: begin
                    if (outFire) begin
                        if (OUT_LAST) begin
                            // Next packet begins on lane 0 of a new line
                            state <= idle;
                            lane <= '0;
                        end else begin
                            lane <= lane + 1'b1;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

// ==== txBufTop.sv ====
`timescale 1ns/1ps

module txBufTop (
    input  logic            CLK,
    input  logic            RST_IN,
    input  txBufPkg::word_t IN_DATA,
    input  logic            IN_VALID,
    input  logic            IN_LAST,
    output logic            IN_READY,
    output txBufPkg::word_t OUT_DATA,
    output logic            OUT_VALID,
    output logic            OUT_START,
    output logic            OUT_LAST,
    input  logic            OUT_READY
);

    txBufPkg::line_t     lineData;
    logic                lineValid;
    logic                lineStart;
    txBufPkg::laneMask_t lineWordValid;
    txBufPkg::laneMask_t lineEndFlags;
    logic                lineReady;
    txBufPkg::line_t     rdData;
    logic                rdStart;
    txBufPkg::laneMask_t rdEndFlags;
    txBufPkg::laneMask_t rdWordValid;
    txBufPkg::laneMask_t rdWordReady;
    logic                rdPacketValid;

    txWordPacker packer (
        .CLK             (CLK),
        .RST_IN          (RST_IN),
        .IN_DATA         (IN_DATA),
        .IN_VALID        (IN_VALID),
        .IN_LAST         (IN_LAST),
        .IN_READY        (IN_READY),
        .LINE_DATA       (lineData),
        .LINE_VALID      (lineValid),
        .LINE_START      (lineStart),
        .LINE_WORD_VALID (lineWordValid),
        .LINE_END_FLAGS  (lineEndFlags),
        .LINE_READY      (lineReady)
    );

    txDataFifo buffer (
        .CLK             (CLK),
        .RST_IN          (RST_IN),
        .LINE_DATA       (lineData),
        .LINE_VALID      (lineValid),
        .LINE_START      (lineStart),
        .LINE_WORD_VALID (lineWordValid),
        .LINE_END_FLAGS  (lineEndFlags),
        .LINE_READY      (lineReady),
        .RD_WORD_READY   (rdWordReady),
        .RD_DATA         (rdData),
        .RD_START        (rdStart),
        .RD_END_FLAGS    (rdEndFlags),
        .RD_WORD_VALID   (rdWordValid),
        .RD_PACKET_VALID (rdPacketValid)
    );

    txWordSerializer serializer (
        .CLK             (CLK),
        .RST_IN          (RST_IN),
        .RD_DATA         (rdData),
        .RD_START        (rdStart),
        .RD_END_FLAGS    (rdEndFlags),
        .RD_WORD_VALID   (rdWordValid),
        .RD_PACKET_VALID (rdPacketValid),
        .RD_WORD_READY   (rdWordReady),
        .OUT_DATA        (OUT_DATA),
        .OUT_VALID       (OUT_VALID),
        .OUT_START       (OUT_START),
        .OUT_LAST        (OUT_LAST),
        .OUT_READY       (OUT_READY)
    );

endmodule

// ==== txBuf_props.sv ====
`timescale 1ns/1ps

module txBufProps (
    input logic                CLK,
    input logic                RST_IN,
    input txBufPkg::pktCount_t PKT_COUNT,
    input logic                LINE_VALID,
    input logic                LINE_READY,
    input txBufPkg::laneMask_t LINE_END_FLAGS,
    input txBufPkg::laneMask_t RD_WORD_VALID,
    input txBufPkg::laneMask_t RD_WORD_READY,
    input txBufPkg::laneMask_t RD_END_FLAGS,
    input logic                RD_PACKET_VALID,
    input txBufPkg::word_t     OUT_DATA,
    input logic                OUT_VALID,
    input logic                OUT_READY
);

    int assertFailures = 0;
    int storedPackets;

    // Whole packets held anywhere between the line side and the read side
    always_ff @(posedge CLK) begin
        if (RST_IN) begin
            storedPackets <= 0;
        end else begin
            storedPackets <= storedPackets
                + int'(LINE_VALID && LINE_READY && (LINE_END_FLAGS != '0))
                - int'((RD_WORD_VALID & RD_WORD_READY & RD_END_FLAGS) != '0);
        end
    end

    // Stored packets stay within the buffer sizing
    countBound: assert property (@(posedge CLK) disable iff (RST_IN)
        PKT_COUNT <= txBufPkg::pktCount_t'(txBufPkg::depthPackets))
        else begin
            assertFailures++;
            $error("packet count above the buffer depth");
        end

    // Read side offers a packet only while a whole one is stored
    emptyNoPacket: assert property (@(posedge CLK) disable iff (RST_IN)
        (storedPackets == 0) |-> !RD_PACKET_VALID)
        else begin
            assertFailures++;
            $error("RD_PACKET_VALID high with no stored packet");
        end

    // A stalled output word stays put
    holdData: assert property (@(posedge CLK) disable iff (RST_IN)
        (OUT_VALID && !OUT_READY) |=> (OUT_VALID && $stable(OUT_DATA)))
        else begin
            assertFailures++;
            $error("OUT_DATA changed while OUT_READY was low");
        end

endmodule

bind txBufTop txBufProps props (
    .CLK             (CLK),
    .RST_IN          (RST_IN),
    .PKT_COUNT       (buffer.pktCount),
    .LINE_VALID      (lineValid),
    .LINE_READY      (lineReady),
    .LINE_END_FLAGS  (lineEndFlags),
    .RD_WORD_VALID   (rdWordValid),
    .RD_WORD_READY   (rdWordReady),
    .RD_END_FLAGS    (rdEndFlags),
    .RD_PACKET_VALID (rdPacketValid),
    .OUT_DATA        (OUT_DATA),
    .OUT_VALID       (OUT_VALID),
    .OUT_READY       (OUT_READY)
);

// ==== tbTxBufChecker.sv ====
`timescale 1ns/1ps

module tbTxBufChecker (
    input logic            CLK,
    input logic            RST_IN,
    input logic            IN_VALID,
    input logic            IN_LAST,
    input logic            IN_READY,
    input txBufPkg::word_t OUT_DATA,
    input logic            OUT_VALID,
    input logic            OUT_START,
    input logic            OUT_LAST,
    input logic            OUT_READY
);

    txBufPkg::laneEntry_t expQ [$];
    int errorCount = 0;
    int testMark = 0;
    int testCount = 0;
    int failedTests = 0;
    int wordsChecked = 0;
    int inDone = 0;
    int outStarts = 0;

    task automatic expectWord(input txBufPkg::laneEntry_t entry);
        expQ.push_back(entry);
    endtask

    function automatic int pendingWords();
        return expQ.size();
    endfunction

    function automatic int totalErrors();
        return errorCount;
    endfunction

    task automatic reportFailure(input string msg);
        $display("%0t %s", $time, msg);
        errorCount++;
    endtask

    task automatic checkResetState();
        if (OUT_VALID !== 1'b0) begin
            $display("[ERROR] %0t OUT_VALID expected 0 actual %b", $time, OUT_VALID);
            errorCount++;
        end
        if (IN_READY !== 1'b1) begin
            $display("[ERROR] %0t IN_READY expected 1 actual %b", $time, IN_READY);
            errorCount++;
        end
    endtask

    task automatic checkPacketBalance();
        if (inDone != outStarts) begin
            reportFailure($sformatf("%0d input packets completed but %0d output packets started",
                                    inDone, outStarts));
        end
    endtask

    task automatic compareWord();
        txBufPkg::word_t expData;
        logic            expStart;
        logic            expLast;
        wordsChecked++;
        if (expQ.size() == 0) begin
            reportFailure("output word arrived with no expected word pending");
            return;
        end
        {expData, expStart, expLast} = expQ.pop_front();
        if (OUT_DATA !== expData) begin
            $display("[ERROR] %0t OUT_DATA expected %h actual %h", $time, expData, OUT_DATA);
            errorCount++;
        end
        if (OUT_START !== expStart) begin
            $display("[ERROR] %0t OUT_START expected %b actual %b", $time, expStart, OUT_START);
            errorCount++;
        end
        if (OUT_LAST !== expLast) begin
            $display("[ERROR] %0t OUT_LAST expected %b actual %b", $time, expLast, OUT_LAST);
            errorCount++;
        end
    endtask

    // Sampled mid-cycle, so values match what the next rising edge transfers
    always @(negedge CLK) begin
        if (!RST_IN) begin
            if (OUT_VALID && OUT_START && outStarts >= inDone) begin
                reportFailure("output packet started before its last input word was accepted");
            end
            if (IN_VALID && IN_READY && IN_LAST) begin
                inDone++;
            end
            if (OUT_VALID && OUT_READY) begin
                if (OUT_START) begin
                    outStarts++;
                end
                compareWord();
            end
        end
    end

    task automatic finishTest(input string name);
        int errs;
        errs = errorCount - testMark;
        testMark = errorCount;
        testCount++;
        if (errs != 0) begin
            failedTests++;
        end
        $display("Test %0d %s: %s with %0d errors", testCount, name,
                 (errs == 0) ? "PASS" : "FAIL", errs);
    endtask

    task automatic printSummary();
        $display("Tests %0d, failed %0d, words checked %0d, errors %0d",
                 testCount, failedTests, wordsChecked, errorCount);
    endtask

endmodule

// ==== tbTxBuf.sv ====
`timescale 1ns/1ps

module tbTxBuf;

    localparam int clkPeriod = 40;
    localparam int resetCycles = 16;
    localparam int maxWords = 16;
    localparam int depthPackets = 4;
    localparam int stressPackets = 200;
    localparam int waitLimit = 4000;
    localparam int stallLimit = 64;
    localparam int seed = 32'h23c3_056e;

    logic            CLK;
    logic            RST_IN;
    txBufPkg::word_t IN_DATA;
    logic            IN_VALID;
    logic            IN_LAST;
    logic            IN_READY;
    txBufPkg::word_t OUT_DATA;
    logic            OUT_VALID;
    logic            OUT_START;
    logic            OUT_LAST;
    logic            OUT_READY;
    int              readyMode = 0;
    bit              timedOut = 1'b0;
    bit              stalled = 1'b0;

    txBufTop dut (
        .CLK       (CLK),
        .RST_IN    (RST_IN),
        .IN_DATA   (IN_DATA),
        .IN_VALID  (IN_VALID),
        .IN_LAST   (IN_LAST),
        .IN_READY  (IN_READY),
        .OUT_DATA  (OUT_DATA),
        .OUT_VALID (OUT_VALID),
        .OUT_START (OUT_START),
        .OUT_LAST  (OUT_LAST),
        .OUT_READY (OUT_READY)
    );

    tbTxBufChecker scoreboard (
        .CLK       (CLK),
        .RST_IN    (RST_IN),
        .IN_VALID  (IN_VALID),
        .IN_LAST   (IN_LAST),
        .IN_READY  (IN_READY),
        .OUT_DATA  (OUT_DATA),
        .OUT_VALID (OUT_VALID),
        .OUT_START (OUT_START),
        .OUT_LAST  (OUT_LAST),
        .OUT_READY (OUT_READY)
    );

    initial begin
        CLK = 1'b0;
        forever #(clkPeriod / 2) CLK = ~CLK;
    end

    // Output ready is high in mode 0, low in mode 1 and random otherwise
    initial begin
        OUT_READY = 1'b0;
        forever begin
            @(posedge CLK);
            #1;
            case (readyMode)
                0: OUT_READY = 1'b1;
                1: OUT_READY = 1'b0;
                default: OUT_READY = $urandom_range(0, 3) != 0;
            endcase
        end
    end

    // Expected word idx of a packet of len words
    function automatic txBufPkg::laneEntry_t expectedEntry(input txBufPkg::word_t data,
                                                           input int idx, input int len);
        return {data, idx == 0, idx == len - 1};
    endfunction

    task automatic nextCycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic markTimeout(input string what);
        scoreboard.reportFailure($sformatf("Timeout: %s", what));
        timedOut = 1'b1;
    endtask

    task automatic offerWord(input txBufPkg::word_t data, input logic last,
                             input int limit, output logic accepted);
        logic readyNow;
        int   cycles;
        IN_DATA = data;
        IN_LAST = last;
        IN_VALID = 1'b1;
        accepted = 1'b0;
        cycles = 0;
        while (!accepted && cycles < limit && !timedOut) begin
            readyNow = IN_READY;
            nextCycle();
            accepted = readyNow;
            cycles++;
        end
    endtask

    task automatic sendPacket(input int len, input bit gaps, input int firstWait);
        txBufPkg::word_t words [maxWords];
        logic            accepted;
        for (int i = 0; i < len; i++) begin
            words[i] = $urandom;
            scoreboard.expectWord(expectedEntry(words[i], i, len));
        end
        for (int i = 0; i < len; i++) begin
            if (gaps && $urandom_range(0, 3) == 0) begin
                IN_VALID = 1'b0;
                repeat ($urandom_range(1, 3)) begin
                    nextCycle();
                end
            end
            offerWord(words[i], i == len - 1, firstWait, accepted);
            if (!accepted && !timedOut && firstWait < waitLimit) begin
                // Input side stalled, so release the output
                stalled = 1'b1;
                readyMode = 0;
                offerWord(words[i], i == len - 1, waitLimit, accepted);
            end
            if (!accepted && !timedOut) begin
                markTimeout("input word was not accepted by the DUT");
            end
        end
        IN_VALID = 1'b0;
    endtask

    task automatic waitDrain();
        int cycles;
        cycles = 0;
        while (scoreboard.pendingWords() != 0 && cycles < waitLimit && !timedOut) begin
            nextCycle();
            cycles++;
        end
        if (scoreboard.pendingWords() != 0 && !timedOut) begin
            markTimeout("output stream did not deliver all expected words");
        end
        // Catch any extra words behind the last expected one
        repeat (8) begin
            nextCycle();
        end
    endtask

    task automatic runBackPressure();
        int sent;
        stalled = 1'b0;
        readyMode = 1;
        sent = 0;
        while (!stalled && sent < depthPackets + 2 && !timedOut) begin
            sendPacket(maxWords, 1'b0, stallLimit);
            if (!stalled) begin
                sent++;
            end
        end
        if (!stalled) begin
            scoreboard.reportFailure("IN_READY stayed high with OUT_READY held low");
        end else if (sent > depthPackets) begin
            scoreboard.reportFailure($sformatf("IN_READY dropped only after %0d packets", sent));
        end
        readyMode = 0;
        waitDrain();
    endtask

    initial begin
        void'($urandom(seed));
        RST_IN = 1'b1;
        IN_DATA = '0;
        IN_VALID = 1'b0;
        IN_LAST = 1'b0;
        repeat (resetCycles) begin
            @(posedge CLK);
        end
        #1;
        RST_IN = 1'b0;
        nextCycle();
        scoreboard.checkResetState();
        scoreboard.finishTest("reset_state");

        for (int len = 1; len <= maxWords; len++) begin
            sendPacket(len, 1'b0, waitLimit);
            waitDrain();
        end
        scoreboard.finishTest("every_length");

        for (int n = 0; n < 8; n++) begin
            sendPacket($urandom_range(1, maxWords), 1'b0, waitLimit);
        end
        waitDrain();
        scoreboard.checkPacketBalance();
        scoreboard.finishTest("store_and_forward");

        runBackPressure();
        scoreboard.finishTest("back_pressure");

        readyMode = 2;
        for (int n = 0; n < stressPackets; n++) begin
            sendPacket($urandom_range(1, maxWords), 1'b1, waitLimit);
        end
        readyMode = 0;
        waitDrain();
        scoreboard.checkPacketBalance();
        scoreboard.finishTest("random_stress");

        scoreboard.printSummary();
        if (timedOut || scoreboard.totalErrors() != 0 || dut.props.assertFailures != 0) begin
            $display("Simulation failed");
        end else begin
            $display("Simulation passed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
txBufPkg.sv
txPipeline.sv
txLaneFifo.sv
txDataFifo.sv
txWordPacker.sv
txWordSerializer.sv
txBufTop.sv
txBuf_props.sv
tbTxBufChecker.sv
tbTxBuf.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --top-module tbTxBuf -Mdir obj_dir -f files.f
	-./obj_dir/VtbTxBuf > sim.log 2>&1
	@cat sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@if ! grep -q "Simulation passed" sim.log; then echo "run did not complete"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
